/* camera_tracker.f */
+incdir+include
design/camera_pkg.sv
design/pixel_reconstruct.sv
design/chroma_threshold.sv
design/center_of_mass.sv
design/crosshair_overlay.sv
design/camera_tracker.sv
test/camera_tracker_chk.sv
test/camera_tracker_tb.sv

/* design/camera_pkg.sv */
`include "camera_defs.svh"

package camera_pkg;

   // plain vectors
   typedef logic [7:0] cam_byte_t;
   typedef logic [15:0] rgb565_t;
   typedef logic [`HCOUNT_W-1:0] hcount_t;
   typedef logic [`VCOUNT_W-1:0] vcount_t;
   typedef logic [7:0] chroma_t;
   typedef logic [`SUM_W-1:0] coord_sum_t;
   typedef logic [15:0] pix_count_t;

   // one camera pixel with its raster position
   typedef struct packed {
      logic valid;
      hcount_t hcount;
      vcount_t vcount;
      rgb565_t data;
   } cam_pixel_t;

   // pixel plus its pink mask bit
   typedef struct packed {
      cam_pixel_t pix;
      logic mask;
   } mask_pixel_t;

   // center of mass of one frame
   typedef struct packed {
      hcount_t x;
      vcount_t y;
   } com_t;

   // divider sequencing
   typedef enum logic [1:0] {
      IDLE,
      DIVIDE,
      DONE
   } div_state_t;

endpackage

/* design/camera_tracker.sv */
`include "camera_defs.svh"

module camera_tracker import camera_pkg::*; (
   input logic clk_camera,
   input logic sys_rst_camera,
   input cam_byte_t camera_d_i,
   input logic cam_pclk_i,
   input logic cam_hsync_i,
   input logic cam_vsync_i,
   output mask_pixel_t out_o,
   output com_t com_o,
   output logic com_valid_o
);

   // assembled camera pixels
   cam_pixel_t cam_pix;
   // pixels with pink mask
   mask_pixel_t mask_pix;

   pixel_reconstruct pixel_reconstruct_i (
      .clk_camera(clk_camera),
      .sys_rst_camera(sys_rst_camera),
      .camera_d_i(camera_d_i),
      .cam_pclk_i(cam_pclk_i),
      .cam_hsync_i(cam_hsync_i),
      .cam_vsync_i(cam_vsync_i),
      .pixel_o(cam_pix)
   );

   chroma_threshold chroma_threshold_i (
      .clk_camera(clk_camera),
      .sys_rst_camera(sys_rst_camera),
      .pixel_i(cam_pix),
      .pixel_o(mask_pix)
   );

   // center also feeds the top-level ports
   center_of_mass center_of_mass_i (
      .clk_camera(clk_camera),
      .sys_rst_camera(sys_rst_camera),
      .pixel_i(mask_pix),
      .com_o(com_o),
      .com_valid_o(com_valid_o)
   );

   crosshair_overlay crosshair_overlay_i (
      .clk_camera(clk_camera),
      .sys_rst_camera(sys_rst_camera),
      .pixel_i(mask_pix),
      .com_i(com_o),
      .com_valid_i(com_valid_o),
      .pixel_o(out_o)
   );

endmodule

/* design/center_of_mass.sv */
`include "camera_defs.svh"

module center_of_mass import camera_pkg::*; (
   input logic clk_camera,
   input logic sys_rst_camera,
   input mask_pixel_t pixel_i,
   output com_t com_o,
   output logic com_valid_o
);

   // remainder (16 bits) on top of dividend/quotient
   localparam int DIV_W = `SUM_W + 16;
   localparam int STEP_W = $clog2(`SUM_W);
   localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`SUM_W - 1);

   // running sums for the current frame
   coord_sum_t x_acc;
   coord_sum_t y_acc;
   pix_count_t cnt;

   // sums including the current pixel
   coord_sum_t x_next;
   coord_sum_t y_next;
   pix_count_t cnt_next;

   logic hit;
   logic frame_end;

   // divider working registers
   logic [DIV_W-1:0] x_div;
   logic [DIV_W-1:0] y_div;
   pix_count_t div_d;
   logic [STEP_W-1:0] step;
   div_state_t state;

   // one restoring step: shift in next dividend bit, try subtract
   function automatic logic [DIV_W-1:0] div_step(input logic [DIV_W-1:0] rq,
                                                 input pix_count_t d);
      logic [16:0] trial;
      logic q_bit;
      trial = {rq[DIV_W-1 -: 16], rq[`SUM_W-1]};
      q_bit = 1'b0;
      if (trial >= {1'b0, d}) begin
         trial = trial - {1'b0, d};
         q_bit = 1'b1;
      end
      return {trial[15:0], rq[`SUM_W-2:0], q_bit};
   endfunction

   assign hit = pixel_i.pix.valid & pixel_i.mask;
   assign frame_end = pixel_i.pix.valid
                    && (pixel_i.pix.hcount == hcount_t'(`FRAME_W - 1))
                    && (pixel_i.pix.vcount == vcount_t'(`FRAME_H - 1));

   assign x_next = hit ? x_acc + coord_sum_t'(pixel_i.pix.hcount) : x_acc;
   assign y_next = hit ? y_acc + coord_sum_t'(pixel_i.pix.vcount) : y_acc;
   assign cnt_next = hit ? cnt + pix_count_t'(1) : cnt;

   // accumulation, keeps pace with the pixel stream
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         x_acc <= '0;
         y_acc <= '0;
         cnt <= '0;
      end else if (frame_end) begin
         // totals move to the divider, frame restarts clean
         x_acc <= '0;
         y_acc <= '0;
         cnt <= '0;
      end else begin
         x_acc <= x_next;
         y_acc <= y_next;
         cnt <= cnt_next;
      end
   end

   // divider datapath
   always_ff @(posedge clk_camera) begin
      if (frame_end) begin
         x_div <= {16'd0, x_next};
         y_div <= {16'd0, y_next};
         div_d <= cnt_next;
      end else if (state == DIVIDE) begin
         x_div <= div_step(x_div, div_d);
         y_div <= div_step(y_div, div_d);
      end
   end

   // divider sequencing
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         state <= IDLE;
         step <= '0;
      end else if (frame_end && (cnt_next != '0)) begin
         // empty frames never start a division
         state <= DIVIDE;
         step <= '0;
      end else begin
         case (state)
            DIVIDE: begin
               step <= step + STEP_W'(1);
               if (step == LAST_STEP) begin
                  state <= DONE;
               end
            end
            DONE: begin
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // quotients sit in the low bits, means never exceed the frame size
   assign com_o.x = x_div[`HCOUNT_W-1:0];
   assign com_o.y = y_div[`VCOUNT_W-1:0];
   assign com_valid_o = (state == DONE);

endmodule

/* design/chroma_threshold.sv */
`include "camera_defs.svh"

module chroma_threshold import camera_pkg::*; (
   input logic clk_camera,
   input logic sys_rst_camera,
   input cam_pixel_t pixel_i,
   output mask_pixel_t pixel_o
);

   // 5-6-5 fields widened to 8 bits, low bits zero
   chroma_t red;
   chroma_t green;
   chroma_t blue;

   // 112r - 94g - 18b, signed
   logic signed [17:0] weighted;
   logic signed [17:0] s1_weighted;
   cam_pixel_t s1_pix;

   // cr before clamping
   logic signed [17:0] cr_wide;
   chroma_t cr;

   assign red = {pixel_i.data[15:11], 3'b000};
   assign green = {pixel_i.data[10:5], 2'b00};
   assign blue = {pixel_i.data[4:0], 3'b000};

   assign weighted = 18'sd112 * $signed({10'd0, red})
                   - 18'sd94 * $signed({10'd0, green})
                   - 18'sd18 * $signed({10'd0, blue});

   // stage 1: products
   always_ff @(posedge clk_camera) begin
      s1_pix <= pixel_i;
      s1_weighted <= weighted;
      if (sys_rst_camera) begin
         s1_pix.valid <= 1'b0;
      end
   end

   // offset by 128 * 256, then floor divide by 256
   assign cr_wide = (s1_weighted + 18'sd32768) >>> 8;

   always_comb begin
      if (cr_wide < 18'sd0) begin
         cr = 8'd0;
      end else if (cr_wide > 18'sd255) begin
         cr = 8'd255;
      end else begin
         cr = cr_wide[7:0];
      end
   end

   // stage 2: window compare
   always_ff @(posedge clk_camera) begin
      pixel_o.pix <= s1_pix;
      pixel_o.mask <= (cr >= `CR_LOWER) && (cr <= `CR_UPPER);
      if (sys_rst_camera) begin
         pixel_o.pix.valid <= 1'b0;
      end
   end

endmodule

/* design/crosshair_overlay.sv */
`include "camera_defs.svh"

module crosshair_overlay import camera_pkg::*; (
   input logic clk_camera,
   input logic sys_rst_camera,
   input mask_pixel_t pixel_i,
   input com_t com_i,
   input logic com_valid_i,
   output mask_pixel_t pixel_o
);

   // last center reported
   com_t com_q;
   // set once the first center arrives
   logic seen;
   logic on_cross;

   // pixel on the center's column or line
   assign on_cross = seen
                   && ((pixel_i.pix.hcount == com_q.x)
                   || (pixel_i.pix.vcount == com_q.y));

   always_ff @(posedge clk_camera) begin
      pixel_o <= pixel_i;
      if (on_cross) begin
         pixel_o.pix.data <= `CROSS_COLOR;
      end
      // center only moves on a new result
      if (com_valid_i) begin
         com_q <= com_i;
      end
      if (sys_rst_camera) begin
         seen <= 1'b0;
         pixel_o.pix.valid <= 1'b0;
      end else if (com_valid_i) begin
         seen <= 1'b1;
      end
   end

endmodule

/* design/pixel_reconstruct.sv */
`include "camera_defs.svh"

module pixel_reconstruct import camera_pkg::*; (
   input logic clk_camera,
   input logic sys_rst_camera,
   input cam_byte_t camera_d_i,
   input logic cam_pclk_i,
   input logic cam_hsync_i,
   input logic cam_vsync_i,
   output cam_pixel_t pixel_o
);

   // two-flop synchronizers on the data pins
   cam_byte_t d_meta;
   cam_byte_t d_sync;

   // control pin shift registers
   // bit 0 meta, bit 1 sync, bit 2 previous sync value
   logic [2:0] pclk_q;
   logic [2:0] hsync_q;
   logic [1:0] vsync_q;

   // high byte of the pixel being assembled
   cam_byte_t hi_byte;
   // low while waiting for the high byte
   logic phase;
   hcount_t col;
   vcount_t line;

   logic pclk_rise;
   logic hsync_fall;
   logic byte_take;

   always_ff @(posedge clk_camera) begin
      d_meta <= camera_d_i;
      d_sync <= d_meta;
      if (sys_rst_camera) begin
         pclk_q <= '0;
         hsync_q <= '0;
         vsync_q <= '0;
      end else begin
         pclk_q <= {pclk_q[1:0], cam_pclk_i};
         hsync_q <= {hsync_q[1:0], cam_hsync_i};
         vsync_q <= {vsync_q[0], cam_vsync_i};
      end
   end

   // edges seen on the synchronized copies
   assign pclk_rise = pclk_q[1] & ~pclk_q[2];
   assign hsync_fall = ~hsync_q[1] & hsync_q[2];
   // bytes only count inside an active line
   assign byte_take = pclk_rise & hsync_q[1];

   always_ff @(posedge clk_camera) begin
      // byte capture and pixel fields
      if (byte_take && !phase) begin
         hi_byte <= d_sync;
      end
      if (byte_take && phase) begin
         pixel_o.hcount <= col;
         pixel_o.vcount <= line;
         pixel_o.data <= {hi_byte, d_sync};
      end
      if (sys_rst_camera) begin
         phase <= 1'b0;
         col <= '0;
         line <= '0;
         pixel_o.valid <= 1'b0;
      end else begin
         pixel_o.valid <= 1'b0;
         if (vsync_q[1]) begin
            // frame blanking restarts the raster
            col <= '0;
            line <= '0;
            phase <= 1'b0;
         end else if (hsync_fall) begin
            // end of line
            col <= '0;
            line <= line + vcount_t'(1);
            phase <= 1'b0;
         end else if (byte_take) begin
            phase <= ~phase;
            if (phase) begin
               // low byte completes the pixel
               pixel_o.valid <= 1'b1;
               col <= col + hcount_t'(1);
            end
         end
      end
   end

endmodule

/* include/camera_defs.svh */
`ifndef CAMERA_DEFS_SVH
`define CAMERA_DEFS_SVH

// active frame size in pixels and lines
`define FRAME_W 320
`define FRAME_H 180

// index widths for column and line
`define HCOUNT_W 9
`define VCOUNT_W 8

// pink window on the cr channel, inclusive
`define CR_LOWER 8'hA0
`define CR_UPPER 8'hF0

// crosshair paint, white in rgb565
`define CROSS_COLOR 16'hFFFF

// coordinate sum width
// frame area times largest coordinate fits in 25 bits
`define SUM_W 25

`endif

/* run_sim.sh */
#!/bin/sh
# build the camera tracker testbench with verilator, run it, look for the pass line
verilator --binary --assert --timescale 1ns/100ps --top-module camera_tracker_tb \
   -f camera_tracker.f -o sim_camera_tracker || exit 1
out=$(./obj_dir/sim_camera_tracker +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "NO ERRORS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* test/camera_tracker_chk.sv */
`include "camera_defs.svh"

module camera_tracker_chk import camera_pkg::*; (
   input logic clk_camera,
   input logic sys_rst_camera,
   input mask_pixel_t out_i,
   input com_t com_i,
   input logic com_valid_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // count of failed assertions
   int fail_count = 0;

   // last output coordinate and its expected successor
   hcount_t last_h;
   vcount_t last_v;
   logic have_last;
   hcount_t next_h;
   vcount_t next_v;

   // reference cr of the output pixel
   int red_ref;
   int green_ref;
   int blue_ref;
   int weighted_ref;
   int cr_ref;
   logic mask_ref;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         have_last <= 1'b0;
      end else if (out_i.pix.valid) begin
         have_last <= 1'b1;
         last_h <= out_i.pix.hcount;
         last_v <= out_i.pix.vcount;
      end
   end

   // raster successor wraps at line end and at frame end
   always_comb begin
      if (last_h == hcount_t'(`FRAME_W - 1)) begin
         next_h = '0;
         next_v = (last_v == vcount_t'(`FRAME_H - 1)) ? '0 : last_v + vcount_t'(1);
      end else begin
         next_h = last_h + hcount_t'(1);
         next_v = last_v;
      end
   end

   // cr = 128 + floor((112r - 94g - 18b) / 256), clamped to a byte
   always_comb begin
      red_ref = int'(out_i.pix.data[15:11]) * 8;
      green_ref = int'(out_i.pix.data[10:5]) * 4;
      blue_ref = int'(out_i.pix.data[4:0]) * 8;
      weighted_ref = 112 * red_ref - 94 * green_ref - 18 * blue_ref;
      if (weighted_ref < 0) begin
         cr_ref = 128 - (255 - weighted_ref) / 256;
      end else begin
         cr_ref = 128 + weighted_ref / 256;
      end
      if (cr_ref < 0) begin
         cr_ref = 0;
      end else if (cr_ref > 255) begin
         cr_ref = 255;
      end
      mask_ref = (cr_ref >= `CR_LOWER) && (cr_ref <= `CR_UPPER);
   end

   // outputs quiet in reset and right after it
   reset_quiet: assert property (@(posedge clk_camera)
      sys_rst_camera |=> !out_i.pix.valid && !com_valid_i)
      else begin $error("output strobe during reset"); fail_count++; end

   after_reset_quiet: assert property (@(posedge clk_camera)
      $fell(sys_rst_camera) |=> !out_i.pix.valid && !com_valid_i)
      else begin $error("output strobe right after reset"); fail_count++; end

   coord_range: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
      out_i.pix.valid |-> (out_i.pix.hcount < `FRAME_W) && (out_i.pix.vcount < `FRAME_H))
      else begin $error("output coordinate outside the frame"); fail_count++; end

   first_coord: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
      out_i.pix.valid && !have_last |-> (out_i.pix.hcount == '0) && (out_i.pix.vcount == '0))
      else begin $error("first output pixel is not at the origin"); fail_count++; end

   coord_order: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
      out_i.pix.valid && have_last
         |-> (out_i.pix.hcount == next_h) && (out_i.pix.vcount == next_v))
      else begin $error("output coordinate out of raster order"); fail_count++; end

   // crosshair pixels carry the mask of the replaced value
   mask_rule: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
      out_i.pix.valid && (out_i.pix.data != `CROSS_COLOR) |-> out_i.mask == mask_ref)
      else begin $error("mask does not follow the cr window"); fail_count++; end

   center_range: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
      com_valid_i |-> (com_i.x < `FRAME_W) && (com_i.y < `FRAME_H))
      else begin $error("center outside the frame"); fail_count++; end

endmodule

bind camera_tracker camera_tracker_chk chk_i (
   .clk_camera(clk_camera),
   .sys_rst_camera(sys_rst_camera),
   .out_i(out_o),
   .com_i(com_o),
   .com_valid_i(com_valid_o)
);

/* test/camera_tracker_tb.sv */
`include "camera_defs.svh"

module camera_tracker_tb import camera_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   // bus timing in clk_camera cycles, one byte per pclk period
   localparam int BYTE_CYC = 4;
   localparam int LINE_GAP = 2;
   localparam int VS_HIGH = 4;
   localparam int VS_GAP = 4;
   localparam int NUM_FRAMES = 3;
   localparam int RESET_CYC = 5;
   localparam int DRAIN_CYC = 64;
   localparam int LINE_CYC = BYTE_CYC * (2 * `FRAME_W + LINE_GAP);
   localparam int FRAME_CYC = BYTE_CYC * (VS_HIGH + VS_GAP) + `FRAME_H * LINE_CYC;
   localparam int CYCLE_LIMIT = NUM_FRAMES * FRAME_CYC + RESET_CYC + DRAIN_CYC + 1000;
   // planted pink block
   localparam int RECT_W = 24;
   localparam int RECT_H = 16;
   localparam rgb565_t PINK = 16'hF81F;

   logic clk_camera = 1'b0;
   logic sys_rst_camera;
   cam_byte_t camera_d;
   logic cam_pclk;
   logic cam_hsync;
   logic cam_vsync;
   mask_pixel_t out_pix;
   com_t com;
   logic com_valid;

   integer seed = 32'hb8b09622;
   int cycles = 0;
   int pix_errors = 0;
   int center_errors = 0;
   int total_errors;

   // sent pixels as they should leave, and centers still due
   cam_pixel_t pix_q[$];
   com_t center_q[$];
   cam_pixel_t exp_pix;
   com_t exp_center;

   // overlay model state
   logic model_seen;
   com_t model_center;

   always #2 clk_camera = ~clk_camera;

   camera_tracker dut_i (
      .clk_camera(clk_camera),
      .sys_rst_camera(sys_rst_camera),
      .camera_d_i(camera_d),
      .cam_pclk_i(cam_pclk),
      .cam_hsync_i(cam_hsync),
      .cam_vsync_i(cam_vsync),
      .out_o(out_pix),
      .com_o(com),
      .com_valid_o(com_valid)
   );

   // one pclk period, byte stable across the rising edge
   task automatic pclk_period(input cam_byte_t value);
      camera_d = value;
      cam_pclk = 1'b0;
      repeat (2) @(negedge clk_camera);
      cam_pclk = 1'b1;
      repeat (2) @(negedge clk_camera);
   endtask

   // sent pixel as the output should show it
   function automatic cam_pixel_t expected_out(input hcount_t h, input vcount_t v,
                                               input rgb565_t value);
      cam_pixel_t e;
      e.valid = 1'b1;
      e.hcount = h;
      e.vcount = v;
      e.data = value;
      if (model_seen && ((h == model_center.x) || (v == model_center.y))) begin
         e.data = `CROSS_COLOR;
      end
      return e;
   endfunction

   task automatic send_frame(input bit planted);
      logic [31:0] rnd;
      int x0;
      int y0;
      int h;
      int v;
      int sum_x;
      int sum_y;
      rgb565_t value;
      com_t center;
      rnd = $random(seed);
      x0 = int'(rnd % (`FRAME_W - RECT_W));
      rnd = $random(seed);
      y0 = int'(rnd % (`FRAME_H - RECT_H));
      sum_x = 0;
      sum_y = 0;
      center = '0;
      if (planted) begin
         // mean of the block, rounded down
         for (v = y0; v < y0 + RECT_H; v++) begin
            for (h = x0; h < x0 + RECT_W; h++) begin
               sum_x += h;
               sum_y += v;
            end
         end
         center.x = hcount_t'(sum_x / (RECT_W * RECT_H));
         center.y = vcount_t'(sum_y / (RECT_W * RECT_H));
         center_q.push_back(center);
      end
      cam_hsync = 1'b0;
      cam_vsync = 1'b1;
      repeat (VS_HIGH) pclk_period(8'h00);
      cam_vsync = 1'b0;
      repeat (VS_GAP) pclk_period(8'h00);
      for (v = 0; v < `FRAME_H; v++) begin
         cam_hsync = 1'b1;
         for (h = 0; h < `FRAME_W; h++) begin
            if (planted && (h >= x0) && (h < x0 + RECT_W)
                && (v >= y0) && (v < y0 + RECT_H)) begin
               value = PINK;
            end else begin
               // red msb low, green msb high, cr stays below the window
               rnd = $random(seed);
               value = (rnd[15:0] & 16'h7FFF) | 16'h0400;
            end
            pix_q.push_back(expected_out(hcount_t'(h), vcount_t'(v), value));
            pclk_period(value[15:8]);
            pclk_period(value[7:0]);
         end
         cam_hsync = 1'b0;
         repeat (LINE_GAP) pclk_period(8'h00);
      end
      // next frame draws through this center
      if (planted) begin
         model_seen = 1'b1;
         model_center = center;
      end
   endtask

   // scoreboard on the pixel output
   always @(negedge clk_camera) begin
      if (out_pix.pix.valid) begin
         if (pix_q.size() == 0) begin
            $display("** Error at %0t: output pixel with no pixel sent", $time);
            pix_errors++;
         end else begin
            exp_pix = pix_q.pop_front();
            if (out_pix.pix != exp_pix) begin
               $display("** Error at %0t: pixel (%0d,%0d) %h, expected (%0d,%0d) %h",
                        $time, out_pix.pix.hcount, out_pix.pix.vcount, out_pix.pix.data,
                        exp_pix.hcount, exp_pix.vcount, exp_pix.data);
               pix_errors++;
            end
         end
      end
   end

   // center results against the planted blocks
   always @(negedge clk_camera) begin
      if (com_valid) begin
         if (center_q.size() == 0) begin
            $display("** Error at %0t: center pulse without a masked frame", $time);
            center_errors++;
         end else begin
            exp_center = center_q.pop_front();
            if (com != exp_center) begin
               $display("** Error at %0t: center (%0d,%0d), expected (%0d,%0d)",
                        $time, com.x, com.y, exp_center.x, exp_center.y);
               center_errors++;
            end
         end
      end
   end

   always @(posedge clk_camera) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial begin
      sys_rst_camera = 1'b1;
      camera_d = '0;
      cam_pclk = 1'b0;
      cam_hsync = 1'b0;
      cam_vsync = 1'b0;
      model_seen = 1'b0;
      model_center = '0;
      repeat (RESET_CYC) @(negedge clk_camera);
      sys_rst_camera = 1'b0;
      @(negedge clk_camera);
      // middle frame has no pink, no center expected
      send_frame(1'b1);
      send_frame(1'b0);
      send_frame(1'b1);
      while ((pix_q.size() != 0) || (center_q.size() != 0)) begin
         @(negedge clk_camera);
      end
      repeat (DRAIN_CYC) @(negedge clk_camera);
      total_errors = pix_errors + center_errors + dut_i.chk_i.fail_count;
      $display("error counts: pixel %0d, center %0d, assertion %0d",
               pix_errors, center_errors, dut_i.chk_i.fail_count);
      if (total_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule
